// File: Makefile
VERILATOR ?= verilator
TOP       ?= axi_bus_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Verification passed

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) axi_master_settings.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: axi_bus_chk.sv
module axi_bus_chk (
    input logic clk,
    input logic rst,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic arvalid,
    input logic arready,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic w_success,
    input logic w_fail
);
    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench at the end of the run
    int fail_count = 0;

    // a valid stays up until its ready
    aw_hold: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
        else begin
            $error("awvalid dropped before awready");
            fail_count++;
        end
    w_hold: assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
        else begin
            $error("wvalid dropped before wready");
            fail_count++;
        end
    ar_hold: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
        else begin
            $error("arvalid dropped before arready");
            fail_count++;
        end
    b_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end
    r_hold: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
        else begin
            $error("rvalid dropped before rready");
            fail_count++;
        end

    // one-cycle acceptance only
    b_accept: assert property (@(posedge clk) disable iff (rst) !bready || bvalid)
        else begin
            $error("bready raised without bvalid");
            fail_count++;
        end
    r_accept: assert property (@(posedge clk) disable iff (rst) !rready || rvalid)
        else begin
            $error("rready raised without rvalid");
            fail_count++;
        end

    w_result: assert property (@(posedge clk) disable iff (rst) !(w_success && w_fail))
        else begin
            $error("w_success and w_fail in the same cycle");
            fail_count++;
        end

endmodule

bind axi_master_top axi_bus_chk axi_bus_chk_inst (
    .clk       (clk),
    .rst       (rst),
    .awvalid   (awvalid),
    .awready   (awready),
    .wvalid    (wvalid),
    .wready    (wready),
    .arvalid   (arvalid),
    .arready   (arready),
    .bvalid    (bvalid),
    .bready    (bready),
    .rvalid    (rvalid),
    .rready    (rready),
    .w_success (w_success),
    .w_fail    (w_fail)
);

// File: axi_bus_monitor.sv
`include "axi_master_settings.svh"

module axi_bus_monitor #(
    parameter int NAME_W = 128
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   re,
    input  logic                   we,
    input  logic [`AXI_DATA_W-1:0] rdata,
    input  logic                   r_success,
    input  logic                   r_fail,
    input  logic                   r_timeout,
    input  logic                   w_success,
    input  logic                   w_fail,
    input  logic                   w_busy,
    input  logic [NAME_W-1:0]      exp_name,
    input  int                     exp_index,
    input  logic                   exp_write,
    input  logic                   exp_ok,
    input  logic [`AXI_DATA_W-1:0] exp_rdata,
    input  logic                   exp_timeout,
    output int                     error_count,
    output int                     check_count
);
    timeunit 1ns;
    timeprecision 100ps;

    logic done_r;
    logic done_w;
    logic pending;
    logic write_active;
    logic timeout_level;

    assign done_r = r_success || r_fail;
    assign done_w = w_success || w_fail;

    task automatic check_outcome();
        logic got_ok;
        check_count++;
        got_ok = exp_write ? w_success : r_success;
        if ((exp_write && done_r) || (!exp_write && done_w)) begin
            $display("Error: %0s #%0d completed on the wrong channel", exp_name, exp_index);
            error_count++;
        end else if (got_ok !== exp_ok || (r_success && r_fail) || (w_success && w_fail)) begin
            $display("Mismatch: %0s #%0d outcome expected %s actual %s", exp_name, exp_index,
                     exp_ok ? "ok" : "fail", got_ok ? "ok" : "fail");
            error_count++;
        end else if (!exp_write && rdata !== exp_rdata) begin
            $display("Mismatch: %0s #%0d rdata expected %08h actual %08h", exp_name, exp_index,
                     exp_rdata, rdata);
            error_count++;
        end
        if (!exp_write) begin
            if (r_timeout !== exp_timeout) begin
                $display("Mismatch: %0s #%0d r_timeout expected %0b actual %0b", exp_name,
                         exp_index, exp_timeout, r_timeout);
                error_count++;
            end
            timeout_level = exp_timeout;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            pending       = 1'b0;
            write_active  = 1'b0;
            timeout_level = 1'b0;
            error_count   = 0;
            check_count   = 0;
        end else begin
            if ((done_r || done_w) && !pending) begin
                $display("Error: completion pulse at %0t with no request outstanding", $time);
                error_count++;
            end else if (done_r || done_w) begin
                check_outcome();
            end else if (r_timeout !== timeout_level) begin
                $display("Mismatch: %0s #%0d r_timeout expected %0b actual %0b", exp_name,
                         exp_index, timeout_level, r_timeout);
                error_count++;
            end
            // busy from the cycle after we until the cycle after the result
            if (w_busy !== (write_active && !w_fail)) begin
                $display("Mismatch: %0s #%0d w_busy expected %0b actual %0b", exp_name,
                         exp_index, write_active && !w_fail, w_busy);
                error_count++;
            end
            if (done_r || done_w) begin
                pending      = 1'b0;
                write_active = 1'b0;
            end
            if (re || we) begin
                pending = 1'b1;
            end
            if (we) begin
                write_active = 1'b1;
            end
        end
    end

endmodule

// File: axi_bus_tb.sv
`include "axi_master_settings.svh"

module axi_bus_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NAME_W      = 8 * 16;
    localparam int MAX_ENTRIES = 96;
    localparam int RST_CYCLES  = 16;
    localparam int IDX_W       = $clog2(`AXI_NUM_REGS);

    logic                   clk;
    logic                   rst;
    logic                   re;
    logic                   we;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_DATA_W-1:0] wdata;
    logic [`AXI_DATA_W-1:0] rdata;
    logic                   r_success, r_fail, r_timeout;
    logic                   w_success, w_fail, w_busy;

    // expectation of the entry in flight
    logic [NAME_W-1:0]      exp_name;
    int                     exp_index;
    logic                   exp_write, exp_ok, exp_timeout;
    logic [`AXI_DATA_W-1:0] exp_rdata;
    int                     error_count, check_count;

    logic [NAME_W-1:0]      tbl_name  [MAX_ENTRIES];
    logic                   tbl_write [MAX_ENTRIES];
    logic [`AXI_ADDR_W-1:0] tbl_addr  [MAX_ENTRIES];
    logic [`AXI_DATA_W-1:0] tbl_data  [MAX_ENTRIES];
    logic                   tbl_rand  [MAX_ENTRIES];
    logic                   tbl_ok    [MAX_ENTRIES];
    logic [`AXI_DATA_W-1:0] tbl_exp   [MAX_ENTRIES];
    logic [`AXI_DATA_W-1:0] shadow    [`AXI_NUM_REGS];
    int                     num_entries = 0;
    logic                   table_ready = 1'b0;

    axi_master_top axi_master_top_inst (
        .clk       (clk),
        .rst       (rst),
        .re        (re),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .r_success (r_success),
        .r_fail    (r_fail),
        .r_timeout (r_timeout),
        .w_success (w_success),
        .w_fail    (w_fail),
        .w_busy    (w_busy)
    );

    axi_bus_monitor #(.NAME_W(NAME_W)) axi_bus_monitor_inst (
        .clk         (clk),
        .rst         (rst),
        .re          (re),
        .we          (we),
        .rdata       (rdata),
        .r_success   (r_success),
        .r_fail      (r_fail),
        .r_timeout   (r_timeout),
        .w_success   (w_success),
        .w_fail      (w_fail),
        .w_busy      (w_busy),
        .exp_name    (exp_name),
        .exp_index   (exp_index),
        .exp_write   (exp_write),
        .exp_ok      (exp_ok),
        .exp_rdata   (exp_rdata),
        .exp_timeout (exp_timeout),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic add_entry(
        input logic [NAME_W-1:0]      name,
        input logic                   is_write,
        input logic [`AXI_ADDR_W-1:0] a,
        input logic [`AXI_DATA_W-1:0] d,
        input logic                   rnd,
        input logic                   ok
    );
        tbl_name[num_entries]  = name;
        tbl_write[num_entries] = is_write;
        tbl_addr[num_entries]  = a;
        tbl_data[num_entries]  = d;
        tbl_rand[num_entries]  = rnd;
        tbl_ok[num_entries]    = ok;
        tbl_exp[num_entries]   = '0;
        num_entries++;
    endtask

    task automatic build_table();
        for (int i = 0; i < `AXI_NUM_REGS; i++) begin
            add_entry("reset_read", 1'b0, 32'(i * 4), '0, 1'b0, 1'b1);
        end
        for (int i = 0; i < `AXI_NUM_REGS; i++) begin
            add_entry("write_random", 1'b1, 32'(i * 4), '0, 1'b1, 1'b1);
        end
        for (int i = 0; i < `AXI_NUM_REGS; i++) begin
            add_entry("read_back", 1'b0, 32'(i * 4), '0, 1'b0, 1'b1);
        end
        // would alias onto registers 0 and 1 without the range check
        add_entry("write_oob", 1'b1, 32'h40, 32'hdead_beef, 1'b0, 1'b0);
        add_entry("write_unaligned", 1'b1, 32'h06, 32'h1234_5678, 1'b0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            add_entry("read_unchanged", 1'b0, 32'(i * 4), '0, 1'b0, 1'b1);
        end
        for (int i = 0; i <= `AXI_TIMEOUT_LIMIT; i++) begin
            add_entry("read_oob", 1'b0, 32'(32'h100 + i * 4), '0, 1'b0, 1'b0);
        end
        add_entry("read_recover", 1'b0, 32'h14, '0, 1'b0, 1'b1);
    endtask

    task automatic wait_done(input logic is_write);
        @(posedge clk);
        while (is_write ? !(w_success || w_fail) : !(r_success || r_fail)) begin
            @(posedge clk);
        end
    endtask

    initial begin
        logic [IDX_W-1:0]       idx;
        logic [`AXI_DATA_W-1:0] last_rdata;
        int                     fail_run;
        int                     assert_fails;
        rst         = 1'b1;
        re          = 1'b0;
        we          = 1'b0;
        addr        = '0;
        wdata       = '0;
        exp_name    = '0;
        exp_index   = 0;
        exp_write   = 1'b0;
        exp_ok      = 1'b0;
        exp_rdata   = '0;
        exp_timeout = 1'b0;
        fail_run    = 0;
        last_rdata  = '0;
        for (int i = 0; i < `AXI_NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        void'($urandom(32'hbc9d));
        build_table();
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < num_entries; i++) begin
            if (tbl_rand[i]) begin
                tbl_data[i] = $urandom();
            end
            idx = tbl_addr[i][IDX_W+1:2];
            if (!tbl_write[i]) begin
                // consecutive error reads, held at the limit
                if (tbl_ok[i]) begin
                    tbl_exp[i] = shadow[idx];
                    last_rdata = tbl_exp[i];
                    fail_run   = 0;
                end else begin
                    // a failed read keeps the last good data
                    tbl_exp[i] = last_rdata;
                    if (fail_run < `AXI_TIMEOUT_LIMIT) begin
                        fail_run++;
                    end
                end
            end
            @(negedge clk);
            exp_name    = tbl_name[i];
            exp_index   = i;
            exp_write   = tbl_write[i];
            exp_ok      = tbl_ok[i];
            exp_rdata   = tbl_exp[i];
            exp_timeout = (fail_run >= `AXI_TIMEOUT_LIMIT);
            addr        = tbl_addr[i];
            wdata       = tbl_data[i];
            re          = !tbl_write[i];
            we          = tbl_write[i];
            @(negedge clk);
            re = 1'b0;
            we = 1'b0;
            wait_done(tbl_write[i]);
            if (tbl_write[i] && tbl_ok[i]) begin
                shadow[idx] = tbl_data[i];
            end
        end

        // room for a stray late pulse
        repeat (4) @(negedge clk);
        assert_fails = axi_master_top_inst.axi_bus_chk_inst.fail_count;
        $display("entries %0d, checks %0d, errors %0d, assertion failures %0d",
                 num_entries, check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0 && check_count == num_entries) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready);
        repeat (RST_CYCLES + num_entries * 40) @(posedge clk);
        $display("Timeout: the table of %0d entries did not finish in %0d cycles",
                 num_entries, RST_CYCLES + num_entries * 40);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: axi_fsm.sv
`include "axi_master_settings.svh"

module axi_fsm (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    re,
    output logic                    r_success,
    output logic                    r_timeout,

    input  logic                    we,
    output logic                    w_success,
    output logic                    w_busy,

    input  logic                    arready,
    output logic                    arvalid,

    input  axi_master_pkg::axi_resp_t rresp,
    input  logic                    rvalid,
    output logic                    rready,

    input  logic                    awready,
    output logic                    awvalid,

    input  logic                    wready,
    output logic                    wvalid,

    input  axi_master_pkg::axi_resp_t bresp,
    input  logic                    bvalid,
    output logic                    bready
);
    localparam int CNT_W = $clog2(`AXI_TIMEOUT_LIMIT + 1);

    typedef enum logic [1:0] {
        AW_WAIT,
        AW_SEND,
        AW_RESP_WAIT,
        AW_SUCCESS
    } aw_state_t;

    typedef enum logic [1:0] {
        W_WAIT,
        W_SEND,
        W_RESP_WAIT,
        W_SUCCESS
    } w_state_t;

    typedef enum logic [1:0] {
        R_WAIT,
        R_ADDR_SEND,
        R_DATA_WAIT,
        R_SUCCESS
    } r_state_t;

    aw_state_t        aw_state, aw_n_state;
    w_state_t         w_state, w_n_state;
    r_state_t         r_state, r_n_state;
    logic [CNT_W-1:0] err_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_state <= AW_WAIT;
            w_state  <= W_WAIT;
            r_state  <= R_WAIT;
        end else begin
            aw_state <= aw_n_state;
            w_state  <= w_n_state;
            r_state  <= r_n_state;
        end
    end

    // write address channel
    always_comb begin
        case (aw_state)
            AW_WAIT:      aw_n_state = we ? AW_SEND : AW_WAIT;
            AW_SEND:      aw_n_state = awready ? AW_RESP_WAIT : AW_SEND;
            AW_RESP_WAIT: begin
                if (bvalid) begin
                    aw_n_state = bresp[1] ? AW_WAIT : AW_SUCCESS;
                end else begin
                    aw_n_state = AW_RESP_WAIT;
                end
            end
            AW_SUCCESS:   aw_n_state = w_success ? AW_WAIT : AW_SUCCESS;
            default:      aw_n_state = AW_WAIT;
        endcase
    end

    // write data channel
    always_comb begin
        case (w_state)
            W_WAIT:      w_n_state = we ? W_SEND : W_WAIT;
            W_SEND:      w_n_state = wready ? W_RESP_WAIT : W_SEND;
            W_RESP_WAIT: begin
                if (bvalid) begin
                    w_n_state = bresp[1] ? W_WAIT : W_SUCCESS;
                end else begin
                    w_n_state = W_RESP_WAIT;
                end
            end
            W_SUCCESS:   w_n_state = w_success ? W_WAIT : W_SUCCESS;
            default:     w_n_state = W_WAIT;
        endcase
    end

    // read channel
    always_comb begin
        case (r_state)
            R_WAIT:      r_n_state = re ? R_ADDR_SEND : R_WAIT;
            R_ADDR_SEND: r_n_state = arready ? R_DATA_WAIT : R_ADDR_SEND;
            R_DATA_WAIT: begin
                if (rvalid) begin
                    r_n_state = rresp[1] ? R_WAIT : R_SUCCESS;
                end else begin
                    r_n_state = R_DATA_WAIT;
                end
            end
            R_SUCCESS:   r_n_state = R_WAIT;
            default:     r_n_state = R_WAIT;
        endcase
    end

    assign awvalid = (aw_state == AW_SEND);
    assign wvalid  = (w_state == W_SEND);
    assign arvalid = (r_state == R_ADDR_SEND);

    // accept only in the beat where the slave presents valid
    assign bready = (w_state == W_RESP_WAIT) && bvalid;
    assign rready = (r_state == R_DATA_WAIT) && rvalid;

    // both halves of the write must land in success together
    assign w_success = (aw_state == AW_SUCCESS) && (w_state == W_SUCCESS);
    assign w_busy    = !((aw_state == AW_WAIT) && (w_state == W_WAIT));
    assign r_success = (r_state == R_SUCCESS);

    // error reads since the last good one, saturating at the limit
    always_ff @(posedge clk) begin
        if (rst) begin
            err_count <= '0;
        end else if ((r_state == R_DATA_WAIT) && rvalid) begin
            if (!rresp[1]) begin
                err_count <= '0;
            end else if (err_count != CNT_W'(`AXI_TIMEOUT_LIMIT)) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    assign r_timeout = (err_count == CNT_W'(`AXI_TIMEOUT_LIMIT));

endmodule

// File: axi_lite_regfile.sv
`include "axi_master_settings.svh"

module axi_lite_regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`AXI_ADDR_W-1:0]    awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`AXI_DATA_W-1:0]    wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output axi_master_pkg::axi_resp_t bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`AXI_ADDR_W-1:0]    araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`AXI_DATA_W-1:0]    rdata,
    output axi_master_pkg::axi_resp_t rresp,
    output logic                      rvalid,
    input  logic                      rready
);
    import axi_master_pkg::*;

    localparam int IDX_W  = $clog2(`AXI_NUM_REGS);
    localparam int WAIT_W = (`AXI_SLAVE_WAIT > 1) ? $clog2(`AXI_SLAVE_WAIT) : 1;

    logic [`AXI_DATA_W-1:0] regs [`AXI_NUM_REGS];
    logic [`AXI_ADDR_W-1:0] aw_addr_q;
    logic [`AXI_DATA_W-1:0] w_data_q;
    logic                   aw_held, w_held;
    logic                   aw_take, w_take, ar_take;
    logic                   wr_commit;
    logic [`AXI_ADDR_W-1:0] wr_addr;
    logic [`AXI_DATA_W-1:0] wr_data;

    // per channel: 0 = aw, 1 = w, 2 = ar
    logic [2:0]        ch_valid, ch_open, ch_ready;
    logic [WAIT_W-1:0] wait_cnt [3];

    function automatic logic addr_ok(input logic [`AXI_ADDR_W-1:0] a);
        return (a[1:0] == 2'b00) && (a[`AXI_ADDR_W-1:2] < (`AXI_ADDR_W-2)'(`AXI_NUM_REGS));
    endfunction

    assign ch_valid = {arvalid, wvalid, awvalid};
    // no new beat while a response is still outstanding
    assign ch_open  = {!rvalid, !w_held && !bvalid, !aw_held && !bvalid};

    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (rst) begin
                wait_cnt[i] <= '0;
                ch_ready[i] <= 1'b0;
            end else begin
                ch_ready[i] <= 1'b0;
                if (ch_valid[i] && ch_open[i] && !ch_ready[i]) begin
                    if (wait_cnt[i] == WAIT_W'(`AXI_SLAVE_WAIT - 1)) begin
                        ch_ready[i] <= 1'b1;
                        wait_cnt[i] <= '0;
                    end else begin
                        wait_cnt[i] <= wait_cnt[i] + 1'b1;
                    end
                end else if (!ch_valid[i]) begin
                    wait_cnt[i] <= '0;
                end
            end
        end
    end

    assign awready = ch_ready[0];
    assign wready  = ch_ready[1];
    assign arready = ch_ready[2];

    assign aw_take = awvalid && awready;
    assign w_take  = wvalid && wready;
    assign ar_take = arvalid && arready;

    // address and data may arrive in either order
    assign wr_addr   = aw_take ? awaddr : aw_addr_q;
    assign wr_data   = w_take ? wdata : w_data_q;
    assign wr_commit = (aw_held || aw_take) && (w_held || w_take) && !bvalid;

    always_ff @(posedge clk) begin
        if (aw_take) begin
            aw_addr_q <= awaddr;
        end
        if (w_take) begin
            w_data_q <= wdata;
        end
        if (wr_commit) begin
            bresp <= addr_ok(wr_addr) ? OKAY : SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            regs    <= '{default: '0};
        end else begin
            if (wr_commit) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
                if (addr_ok(wr_addr)) begin
                    regs[wr_addr[IDX_W+1:2]] <= wr_data;
                end
            end else begin
                if (aw_take) begin
                    aw_held <= 1'b1;
                end
                if (w_take) begin
                    w_held <= 1'b1;
                end
                if (bvalid && bready) begin
                    bvalid <= 1'b0;
                end
            end
        end
    end

    // read response, held until rready
    always_ff @(posedge clk) begin
        if (ar_take) begin
            if (addr_ok(araddr)) begin
                rdata <= regs[araddr[IDX_W+1:2]];
                rresp <= OKAY;
            end else begin
                rdata <= '0;
                rresp <= SLVERR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (ar_take) begin
            rvalid <= 1'b1;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

// File: axi_master_datapath.sv
`include "axi_master_settings.svh"

module axi_master_datapath (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      re,
    input  logic                      we,
    input  logic [`AXI_ADDR_W-1:0]    addr,
    input  logic [`AXI_DATA_W-1:0]    wdata_in,
    input  logic                      rvalid,
    input  logic                      rready,
    input  axi_master_pkg::axi_resp_t rresp,
    input  logic [`AXI_DATA_W-1:0]    rdata_bus,
    input  logic                      bvalid,
    input  logic                      bready,
    input  axi_master_pkg::axi_resp_t bresp,
    output logic [`AXI_ADDR_W-1:0]    awaddr,
    output logic [`AXI_ADDR_W-1:0]    araddr,
    output logic [`AXI_DATA_W-1:0]    wdata,
    output logic [`AXI_DATA_W-1:0]    rdata,
    output logic                      r_fail,
    output logic                      w_fail
);
    logic r_beat;
    logic b_beat;

    assign r_beat = rvalid && rready;
    assign b_beat = bvalid && bready;

    // request payload, sampled on the strobe
    always_ff @(posedge clk) begin
        if (we) begin
            awaddr <= addr;
            wdata  <= wdata_in;
        end
        if (re) begin
            araddr <= addr;
        end
    end

    // last good read, lines up with r_success
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (r_beat && !rresp[1]) begin
            rdata <= rdata_bus;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_fail <= 1'b0;
            w_fail <= 1'b0;
        end else begin
            r_fail <= r_beat && rresp[1];
            w_fail <= b_beat && bresp[1];
        end
    end

endmodule

// File: axi_master_pkg.sv
package axi_master_pkg;

    // AXI response code, bit 1 marks an error
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

endpackage

// File: axi_master_settings.svh
`ifndef AXI_MASTER_SETTINGS_SVH
`define AXI_MASTER_SETTINGS_SVH

// byte address and data widths of the AXI-Lite bus
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// slave register bank, word addresses 0x00 to 0x3C
`define AXI_NUM_REGS 16

// SLVERR read responses before r_timeout
`define AXI_TIMEOUT_LIMIT 10

// slave delay from valid to ready
`define AXI_SLAVE_WAIT 2

`endif

// File: axi_master_top.sv
`include "axi_master_settings.svh"

module axi_master_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   re,
    input  logic                   we,
    input  logic [`AXI_ADDR_W-1:0] addr,
    input  logic [`AXI_DATA_W-1:0] wdata,
    output logic [`AXI_DATA_W-1:0] rdata,
    output logic                   r_success,
    output logic                   r_fail,
    output logic                   r_timeout,
    output logic                   w_success,
    output logic                   w_fail,
    output logic                   w_busy
);
    import axi_master_pkg::*;

    // AXI-Lite bus between master and slave
    logic [`AXI_ADDR_W-1:0] awaddr;
    logic                   awvalid, awready;
    logic [`AXI_DATA_W-1:0] axi_wdata;
    logic                   wvalid, wready;
    axi_resp_t              bresp;
    logic                   bvalid, bready;
    logic [`AXI_ADDR_W-1:0] araddr;
    logic                   arvalid, arready;
    logic [`AXI_DATA_W-1:0] axi_rdata;
    axi_resp_t              rresp;
    logic                   rvalid, rready;

    axi_fsm axi_fsm_inst (
        .clk       (clk),
        .rst       (rst),
        .re        (re),
        .r_success (r_success),
        .r_timeout (r_timeout),
        .we        (we),
        .w_success (w_success),
        .w_busy    (w_busy),
        .arready   (arready),
        .arvalid   (arvalid),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .awready   (awready),
        .awvalid   (awvalid),
        .wready    (wready),
        .wvalid    (wvalid),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    axi_master_datapath axi_master_datapath_inst (
        .clk       (clk),
        .rst       (rst),
        .re        (re),
        .we        (we),
        .addr      (addr),
        .wdata_in  (wdata),
        .rvalid    (rvalid),
        .rready    (rready),
        .rresp     (rresp),
        .rdata_bus (axi_rdata),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .awaddr    (awaddr),
        .araddr    (araddr),
        .wdata     (axi_wdata),
        .rdata     (rdata),
        .r_fail    (r_fail),
        .w_fail    (w_fail)
    );

    axi_lite_regfile axi_lite_regfile_inst (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (axi_wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (axi_rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

// File: sources.f
+incdir+.
axi_master_pkg.sv
axi_fsm.sv
axi_master_datapath.sv
axi_lite_regfile.sv
axi_master_top.sv
axi_bus_chk.sv
axi_bus_monitor.sv
axi_bus_tb.sv
